// ==== flist.f ====
src/rv_pipe_pkg.sv
src/rv_credit_fifo.sv
src/rv_regfile.sv
src/id_hazard.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_credit_tx.sv
src/rv_pipe_top.sv
testbench/tb_checker.sv
testbench/tb_rv_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_rv_pipe \
    --Mdir obj_dir -o tb_rv_pipe > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_rv_pipe > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log
if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/tb_rv_pipe.sv ====
`timescale 1ns/10ps

module tb_rv_pipe;

    import rv_pipe_pkg::*;

    logic            clk        = 1'b0;
    logic            out_credit = 1'b0;
    logic            gap_bit    = 1'b0;
    logic [31:0]     lfsr       = 32'h6a47_7a5e;
    int              sink_held  = 0; // results sitting in the sink's slots.
    int              returned   = 0; // in_credit pulses seen by the source.
    logic            rst_n;
    logic            in_valid;
    instr_t          in_instr;
    logic [xlen-1:0] exp_data;
    logic            in_credit;
    logic            out_valid;
    wb_t             out_wb;
    instr_t          table_instr [$];
    logic [xlen-1:0] table_exp [$];
    int              data_errors;
    int              credit_errors;
    int              results_seen;
    int              in_credit_pulses;
    int              timeout_errors;
    int              count_errors;
    int              sent;
    int              idx;
    int              waited;

    rv_pipe_top u_dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_instr(in_instr),
        .in_credit(in_credit), .out_valid(out_valid), .out_wb(out_wb), .out_credit(out_credit)
    );

    tb_checker u_chk (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_instr(in_instr),
        .exp_data(exp_data), .in_credit(in_credit), .out_valid(out_valid), .out_wb(out_wb),
        .out_credit(out_credit), .data_errors(data_errors), .credit_errors(credit_errors),
        .results_seen(results_seen), .in_credit_pulses(in_credit_pulses)
    );

    always #20 clk = ~clk; // 40 ns period.

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic add_row(input alu_op_e op, input int rd, input int rs1, input int rs2,
                           input int imm, input logic [xlen-1:0] exp_val);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd[reg_addr_width-1:0];
        ins.rs1 = rs1[reg_addr_width-1:0];
        ins.rs2 = rs2[reg_addr_width-1:0];
        ins.imm = imm[imm_width-1:0];
        table_instr.push_back(ins);
        table_exp.push_back(exp_val);
    endtask

    // ------------------------------------------------------------
    // stimulus table: op, rd, rs1, rs2, imm, expected data
    // ------------------------------------------------------------
    task automatic load_table();
        add_row(alu_addi,  1,  0, 0,     5, 32'h0000_0005);
        add_row(alu_addi,  2,  0, 0,    -3, 32'hffff_fffd); // negative immediate.
        add_row(alu_add,   3,  1, 2,     0, 32'h0000_0002);
        add_row(alu_sub,   4,  1, 2,     0, 32'h0000_0008);
        add_row(alu_and,   5,  1, 2,     0, 32'h0000_0005);
        add_row(alu_or,    6,  1, 2,     0, 32'hffff_fffd);
        add_row(alu_xor,   7,  1, 2,     0, 32'hffff_fff8);
        add_row(alu_addi,  8,  2, 0,  2047, 32'h0000_07fc);
        add_row(alu_addi,  9,  0, 0, -2048, 32'hffff_f800);
        add_row(alu_addi,  9,  9, 0, -2048, 32'hffff_f000);
        add_row(alu_addi, 10,  6, 0,     3, 32'h0000_0000); // wraps to zero.
        add_row(alu_addi, 11,  1, 0,     1, 32'h0000_0006);
        add_row(alu_add,  11, 11, 11,    0, 32'h0000_000c);
        add_row(alu_sub,  12,  1, 11,    0, 32'hffff_fff9); // depends through rs2.
        add_row(alu_xor,  13,  3, 12,    0, 32'hffff_fffb);
        add_row(alu_or,   13,  0, 13,    0, 32'hffff_fffb);
        add_row(alu_addi,  0,  1, 0,     7, 32'h0000_000c); // x0 write is still reported.
        add_row(alu_add,  14,  0, 1,     0, 32'h0000_0005);
        add_row(alu_sub,   0,  0, 1,     0, 32'hffff_fffb);
        add_row(alu_and,  15,  0, 7,     0, 32'h0000_0000);
        add_row(alu_xor,  16,  8, 8,     0, 32'h0000_0000);
        add_row(alu_add,  16,  8, 16,    0, 32'h0000_07fc);
    endtask

    // one bit for the sink's grant, one bit for the source's idle gap.
    always @(posedge clk) begin
        logic [31:0] state;
        logic        grant;
        grant   = lfsr[0];
        state   = lfsr_step(lfsr);
        gap_bit <= state[0];
        lfsr    <= lfsr_step(state);
        if (!rst_n) begin
            out_credit <= 1'b0;
            sink_held  <= 0;
        end else begin
            out_credit <= grant && (sink_held > 0); // frees one slot now and then.
            sink_held  <= sink_held + int'(out_valid) - int'(grant && (sink_held > 0));
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            returned <= 0;
        end else if (in_credit) begin
            returned <= returned + 1;
        end
    end

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_instr       = '0;
        exp_data       = '0;
        timeout_errors = 0;
        count_errors   = 0;
        sent           = 0;
        idx            = 0;
        waited         = 0;
        load_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (idx < table_instr.size() && timeout_errors == 0) begin
            @(posedge clk);
            if ((in_depth - sent + returned) > 0 && !gap_bit) begin
                in_valid <= 1'b1;
                in_instr <= table_instr[idx];
                exp_data <= table_exp[idx];
                idx++;
                sent++;
                waited = 0;
            end else begin
                in_valid <= 1'b0;
                waited++;
                if (waited > 400) begin
                    $display("timeout: no input credit came back for instruction %0d", idx);
                    timeout_errors++;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        waited = 0;
        while (timeout_errors == 0 && results_seen < sent) begin
            @(posedge clk);
            waited++;
            if (waited > 1000) begin
                $display("timeout: only %0d of %0d results came out", results_seen, sent);
                timeout_errors++;
            end
        end
        waited = 0;
        while (timeout_errors == 0 && in_credit_pulses < sent) begin
            @(posedge clk);
            waited++;
            if (waited > 100) begin
                $display("timeout: %0d input credits returned for %0d instructions",
                         in_credit_pulses, sent);
                timeout_errors++;
            end
        end
        repeat (10) @(posedge clk); // a stray extra result would show up here.
        if (results_seen != sent || in_credit_pulses != sent) begin
            count_errors++;
            $display("result count %0d or credit count %0d differs from %0d instructions sent",
                     results_seen, in_credit_pulses, sent);
        end
        $display("errors: data %0d, credit %0d, count %0d, timeout %0d",
                 data_errors, credit_errors, count_errors, timeout_errors);
        if (data_errors + credit_errors + count_errors + timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  rv_pipe_pkg::instr_t          in_instr,
    input  logic [rv_pipe_pkg::xlen-1:0] exp_data,
    input  logic                         in_credit,
    input  logic                         out_valid,
    input  rv_pipe_pkg::wb_t             out_wb,
    input  logic                         out_credit,
    output int                           data_errors,
    output int                           credit_errors,
    output int                           results_seen,
    output int                           in_credit_pulses
);

    import rv_pipe_pkg::*;

    logic [xlen-1:0] model_regs [32]; // entry 0 is never written.
    wb_t             model_q [$];
    logic [xlen-1:0] exp_q [$];
    int              n_data_err;
    int              n_credit_err;
    int              n_results;
    int              n_in_pulses;
    int              src_credits;     // credits the source should still hold.
    int              sink_credits;    // credits the DUT should still hold.

    function automatic logic [xlen-1:0] apply_rule(input instr_t ins,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        logic [xlen-1:0] imm_ext;
        imm_ext = {{(xlen - imm_width){ins.imm[imm_width-1]}}, ins.imm};
        case (ins.op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_addi: return a + imm_ext; // wraps modulo 2 to the 32nd.
            default:  return 'x;
        endcase
    endfunction

    always @(posedge clk) begin
        wb_t             model;
        logic [xlen-1:0] exp_val;
        if (!rst_n) begin
            model_q.delete();
            exp_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            n_data_err   = 0;
            n_credit_err = 0;
            n_results    = 0;
            n_in_pulses  = 0;
            src_credits  = in_depth;
            sink_credits = out_credits;
        end else begin
            // ------------------------------------------------------------
            // input side
            // ------------------------------------------------------------
            if (in_valid) begin
                model.rd   = in_instr.rd;
                model.data = apply_rule(in_instr, model_regs[in_instr.rs1],
                                        model_regs[in_instr.rs2]);
                model_q.push_back(model);
                exp_q.push_back(exp_data);
                if (in_instr.rd != '0) begin
                    model_regs[in_instr.rd] = model.data; // x0 stays zero.
                end
            end
            src_credits = src_credits - int'(in_valid) + int'(in_credit);
            if (src_credits > in_depth) begin
                n_credit_err++;
                $display("DUT returned an input credit at %0t that was never spent", $time);
            end
            n_in_pulses = n_in_pulses + int'(in_credit);
            // ------------------------------------------------------------
            // output side
            // ------------------------------------------------------------
            if (out_valid) begin
                if (sink_credits == 0) begin
                    n_credit_err++;
                    $display("DUT sent a result at %0t without holding a credit", $time);
                end
                if (model_q.size() == 0) begin
                    n_data_err++;
                    $display("Fail at %0t: result for x%0d with nothing outstanding",
                             $time, out_wb.rd);
                end else begin
                    model   = model_q.pop_front();
                    exp_val = exp_q.pop_front();
                    if (out_wb !== model) begin
                        n_data_err++;
                        $display("Fail at %0t: got x%0d = %h, model x%0d = %h", $time,
                                 out_wb.rd, out_wb.data, model.rd, model.data);
                    end
                    if (out_wb.data !== exp_val) begin
                        n_data_err++;
                        $display("Fail at %0t: got data %h, table expects %h", $time,
                                 out_wb.data, exp_val);
                    end
                end
                n_results++;
            end
            sink_credits = sink_credits - int'(out_valid) + int'(out_credit);
        end
        data_errors      <= n_data_err;
        credit_errors    <= n_credit_err;
        results_seen     <= n_results;
        in_credit_pulses <= n_in_pulses;
    end

endmodule

// ==== src/rv_pipe_top.sv ====
`timescale 1ns/10ps

module rv_pipe_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  rv_pipe_pkg::instr_t in_instr,
    output logic                in_credit,
    output logic                out_valid,
    output rv_pipe_pkg::wb_t    out_wb,
    input  logic                out_credit
);

    import rv_pipe_pkg::*;

    instr_t                    fifo_data;
    ex_req_t                   ex_req;
    wb_t                       res_data;
    logic                      fifo_empty;
    logic                      fifo_pop;
    logic                      uses_rs2;
    logic                      id_valid;
    logic                      stall;
    logic                      ready;
    logic                      ex_valid;
    logic                      ex_busy;
    logic                      wb_busy;
    logic                      we;
    logic                      res_push;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [reg_addr_width-1:0] ex_rd;
    logic [reg_addr_width-1:0] wb_rd;
    logic [reg_addr_width-1:0] wr_addr;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic [xlen-1:0]           wr_data;

    // the source's credits keep the input buffer from overflowing.
    rv_credit_fifo #(.payload_t(instr_t), .depth(in_depth)) u_in_fifo (
        .clk(clk), .rst_n(rst_n), .push(in_valid), .push_data(in_instr),
        .pop(fifo_pop), .pop_data(fifo_data), .empty(fifo_empty), .full()
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .fifo_pop(fifo_pop), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .uses_rs2(uses_rs2), .id_valid(id_valid), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .stall(stall), .ready(ready), .ex_valid(ex_valid),
        .ex_req(ex_req), .in_credit(in_credit)
    );

    id_hazard u_hazard (
        .id_valid(id_valid), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .uses_rs2(uses_rs2), .ex_busy(ex_busy), .ex_rd(ex_rd),
        .wb_busy(wb_busy), .wb_rd(wb_rd), .stall(stall)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .we(we), .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_req(ex_req), .ready(ready),
        .ex_busy(ex_busy), .ex_rd(ex_rd), .wb_busy(wb_busy), .wb_rd(wb_rd), .we(we),
        .wr_addr(wr_addr), .wr_data(wr_data), .res_push(res_push), .res_data(res_data)
    );

    rv_credit_tx u_tx (
        .clk(clk), .rst_n(rst_n), .res_push(res_push), .res_data(res_data),
        .ready(ready), .out_credit(out_credit), .out_valid(out_valid), .out_wb(out_wb)
    );

endmodule

// ==== src/rv_credit_tx.sv ====
`timescale 1ns/10ps

module rv_credit_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             res_push,
    input  rv_pipe_pkg::wb_t res_data,
    output logic             ready,
    input  logic             out_credit,
    output logic             out_valid,
    output rv_pipe_pkg::wb_t out_wb
);

    import rv_pipe_pkg::*;

    logic                    buf_empty;
    logic                    buf_full;
    logic [credit_width-1:0] credits;

    rv_credit_fifo #(
        .payload_t (wb_t),
        .depth     (out_depth)
    ) u_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (res_data),
        .pop       (out_valid),
        .pop_data  (out_wb),
        .empty     (buf_empty),
        .full      (buf_full)
    );

    assign ready     = !buf_full; // a full buffer freezes the whole pipeline.
    assign out_valid = !buf_empty && (credits != '0);

    // A grant and a send in the same cycle cancel out.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_width'(out_credits);
        end else begin
            case ({out_credit, out_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  ex_valid,
    input  rv_pipe_pkg::ex_req_t                  ex_req,
    input  logic                                  ready,
    output logic                                  ex_busy,
    output logic [rv_pipe_pkg::reg_addr_width-1:0] ex_rd,
    output logic                                  wb_busy,
    output logic [rv_pipe_pkg::reg_addr_width-1:0] wb_rd,
    output logic                                  we,
    output logic [rv_pipe_pkg::reg_addr_width-1:0] wr_addr,
    output logic [rv_pipe_pkg::xlen-1:0]           wr_data,
    output logic                                  res_push,
    output rv_pipe_pkg::wb_t                      res_data
);

    import rv_pipe_pkg::*;

    logic [xlen-1:0] alu_result;
    logic            wb_valid;
    logic            wb_writes;
    wb_t             wb_reg;

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb begin
        case (ex_req.op)
            alu_sub: alu_result = ex_req.a - ex_req.b;
            alu_and: alu_result = ex_req.a & ex_req.b;
            alu_or:  alu_result = ex_req.a | ex_req.b;
            alu_xor: alu_result = ex_req.a ^ ex_req.b;
            default: alu_result = ex_req.a + ex_req.b; // add and addi share the adder.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (ready) begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            wb_reg.rd   <= ex_req.rd;
            wb_reg.data <= alu_result;
            wb_writes   <= ex_req.writes_rd;
        end
    end

    // Tags for the stall unit, excluding rd x0.
    assign ex_busy = ex_valid && ex_req.writes_rd;
    assign ex_rd   = ex_req.rd;
    assign wb_busy = wb_valid && wb_writes;
    assign wb_rd   = wb_reg.rd;

    assign res_push = wb_valid && ready; // every instruction is reported, x0 too.
    assign res_data = wb_reg;
    assign we       = res_push && wb_writes;
    assign wr_addr  = wb_reg.rd;
    assign wr_data  = wb_reg.data;

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  fifo_empty,
    input  rv_pipe_pkg::instr_t                   fifo_data,
    output logic                                  fifo_pop,
    output logic [rv_pipe_pkg::reg_addr_width-1:0] rs1_addr,
    output logic [rv_pipe_pkg::reg_addr_width-1:0] rs2_addr,
    output logic                                  uses_rs2,
    output logic                                  id_valid,
    input  logic [rv_pipe_pkg::xlen-1:0]           rs1_data,
    input  logic [rv_pipe_pkg::xlen-1:0]           rs2_data,
    input  logic                                  stall,
    input  logic                                  ready,
    output logic                                  ex_valid,
    output rv_pipe_pkg::ex_req_t                  ex_req,
    output logic                                  in_credit
);

    import rv_pipe_pkg::*;

    instr_t          id_instr;
    ex_req_t         next_req;
    logic [xlen-1:0] imm_ext;
    logic            advance;

    // stall is only ever raised with id_valid, so an empty decode
    // register always refills when the pipeline is moving.
    assign advance  = id_valid && ready && !stall;
    assign fifo_pop = ready && !fifo_empty && !stall;

    assign rs1_addr = id_instr.rs1;
    assign rs2_addr = id_instr.rs2;
    assign uses_rs2 = (id_instr.op != alu_addi); // R-type reads both sources.
    assign imm_ext  = {{(xlen - imm_width){id_instr.imm[imm_width-1]}}, id_instr.imm};

    always_comb begin
        next_req.op        = id_instr.op;
        next_req.rd        = id_instr.rd;
        next_req.a         = rs1_data;
        next_req.b         = uses_rs2 ? rs2_data : imm_ext;
        next_req.writes_rd = (id_instr.rd != '0);
    end

    // ------------------------------------------------------------
    // decode register and execute register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= fifo_pop; // one credit back for every entry taken.
            if (fifo_pop) begin
                id_valid <= 1'b1;
            end else if (advance) begin
                id_valid <= 1'b0;
            end
            if (ready) begin
                ex_valid <= advance; // a stall turns into a bubble.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            id_instr <= fifo_data;
        end
        if (ready) begin
            ex_req <= next_req;
        end
    end

endmodule

// ==== src/id_hazard.sv ====
`timescale 1ns/10ps

module id_hazard (
    input  logic                                  id_valid,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] rs2_addr,
    input  logic                                  uses_rs2,
    input  logic                                  ex_busy,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] ex_rd,
    input  logic                                  wb_busy,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] wb_rd,
    output logic                                  stall
);

    // Each in-flight stage carries its own valid-write tag, so a
    // dependency stalls exactly as long as the producer is still
    // in execute or writeback and not a fixed number of cycles.

    logic rs1_ex_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_wb_hit;
    logic rs1_hit;
    logic rs2_hit;

    // ------------------------------------------------------------
    // per-stage comparisons
    // ------------------------------------------------------------
    // busy flags are never set for rd x0, so x0 sources cannot match.
    assign rs1_ex_hit = ex_busy && (rs1_addr == ex_rd);
    assign rs1_wb_hit = wb_busy && (rs1_addr == wb_rd);
    assign rs2_ex_hit = ex_busy && (rs2_addr == ex_rd);
    assign rs2_wb_hit = wb_busy && (rs2_addr == wb_rd);

    assign rs1_hit = rs1_ex_hit || rs1_wb_hit;
    assign rs2_hit = uses_rs2 && (rs2_ex_hit || rs2_wb_hit); // addi has no rs2.

    // ------------------------------------------------------------
    // stall decision
    // ------------------------------------------------------------
    always_comb begin
        stall = 1'b0;
        if (id_valid) begin
            stall = rs1_hit || rs2_hit; // hold decode until the write lands.
        end
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [rv_pipe_pkg::xlen-1:0]           rs1_data,
    output logic [rv_pipe_pkg::xlen-1:0]           rs2_data,
    input  logic                                  we,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]           wr_data
);

    import rv_pipe_pkg::*;

    // x0 has no storage at all.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // readers see it from the next cycle on.
        end
    end

    // ------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 reads zero.
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/rv_credit_fifo.sv ====
`timescale 1ns/10ps

module rv_credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    payload_t             mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0; // wrap for depths that are not a power of two.
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the fill level alone.
            endcase
        end
    end

    assign pop_data = mem[rd_ptr]; // head is visible without a pop.
    assign empty    = (count == '0);
    assign full     = (count == cnt_width'(depth));

endmodule

// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // ------------------------------------------------------------
    // widths and depths
    // ------------------------------------------------------------
    localparam int xlen           = 32; // data word width.
    localparam int reg_addr_width = 5;  // selects one of x0 to x31.
    localparam int imm_width      = 12; // signed immediate for addi.
    localparam int in_depth       = 4;  // input buffer entries, also the source's credits.
    localparam int out_credits    = 4;  // result slots owned by the sink.
    localparam int out_depth      = 2;  // sender buffer entries.
    localparam int credit_width   = $clog2(out_credits + 1);

    // ------------------------------------------------------------
    // operations and payloads
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_addi = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e                    op;
        logic [reg_addr_width-1:0]  rd;
        logic [reg_addr_width-1:0]  rs1;
        logic [reg_addr_width-1:0]  rs2;  // ignored by addi.
        logic signed [imm_width-1:0] imm; // only addi reads this.
    } instr_t;

    typedef struct packed {
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           data;
    } wb_t;

    // Operand b already carries the extended immediate for addi.
    typedef struct packed {
        alu_op_e                   op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           a;
        logic [xlen-1:0]           b;
        logic                      writes_rd; // clear when rd is x0.
    } ex_req_t;

endpackage
